/* verilog/mem_pkg.sv */
package mem_pkg;

  // geometry of the scratchpad array
  // the word address covers 1024 words of one data word each
  localparam int MEM_ADDR_WIDTH = 10;

  // width of one data word as seen on the APB data buses
  localparam int DATA_WIDTH = 32;

  // each byte lane carries its own parity bit
  localparam int LANE_WIDTH = 8;

  // number of byte lanes in a word
  // this is also the width of the parity word, one bit per lane
  localparam int NUM_LANES = DATA_WIDTH / LANE_WIDTH;

  // low PADDR bits that select a byte inside a word
  // the word address starts right above them
  localparam int BYTE_OFFSET_WIDTH = $clog2(NUM_LANES);

endpackage

/* verilog/apb_pkg.sv */
package apb_pkg;

  // APB byte address width
  // the upper half of the range is register space, the lower half is memory
  localparam int PADDR_WIDTH = 13;

  // PADDR bit that switches from memory to register space
  localparam int REG_SPACE_BIT = 12;

  // register byte offsets inside register space

  // bit 0 inverts the parity stored by later memory writes
  localparam logic [REG_SPACE_BIT-1:0] REG_CTRL = 12'h000;

  // number of reads that failed the parity check, cleared by any write
  localparam logic [REG_SPACE_BIT-1:0] REG_ERR_COUNT = 12'h004;

  // word address of the most recent read that failed the parity check
  localparam logic [REG_SPACE_BIT-1:0] REG_ERR_ADDR = 12'h008;

  // the error counter sticks at all ones instead of wrapping
  localparam int ERR_COUNT_WIDTH = 16;

  // controller states
  // IDLE waits for a setup phase, ACCESS is the first access cycle,
  // READ_WAIT is the second access cycle of a memory read
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    READ_WAIT
  } ctrl_state_t;

endpackage

/* verilog/sram_if.sv */
`timescale 1ns/1ps

interface sram_if #(
  parameter int DW = mem_pkg::DATA_WIDTH,
  parameter int BW = mem_pkg::NUM_LANES
);
  import mem_pkg::*;

  // chip enable, low to start an access in this cycle
  logic                      cen;
  // word address, shared by both arrays
  logic [MEM_ADDR_WIDTH-1:0] a;
  // write enable, low for a write and high for a read
  logic                      wen;
  logic [DW-1:0]             d;
  // per-lane write mask, a low bit lets its lane be written
  logic [BW-1:0]             ben;
  // read data, valid in the cycle after a read request
  logic [DW-1:0]             q;

  // the requesting side
  modport master (output cen, a, wen, d, ben, input q);

  // the array side
  modport slave (input cen, a, wen, d, ben, output q);

endinterface

/* verilog/generic_memory.sv */
`timescale 1ns/1ps

module generic_memory #(
  parameter int ADDR_WIDTH = 10,
  parameter int DATA_WIDTH = 32,
  parameter int LANE_WIDTH = 8
) (
  input  logic   CLK,
  input  logic   init_n,
  sram_if.slave  port
);

  localparam int NUM_WORDS = 2 ** ADDR_WIDTH;
  // a lane is the smallest unit that a write can change
  localparam int NUM_LANES = DATA_WIDTH / LANE_WIDTH;

  // storage has no reset, contents stay undefined until written
  logic [DATA_WIDTH-1:0] mem [NUM_WORDS];
  logic [ADDR_WIDTH-1:0] addr;

  assign addr = port.a;

  // one access per clock edge while the array is out of init
  // a write leaves q unchanged, a read loads q with the addressed word
  always_ff @(posedge CLK)
  begin
    if (init_n && !port.cen)
    begin
      if (!port.wen)
      begin
        // only lanes with a low mask bit take the new data
        for (int l = 0; l < NUM_LANES; l++)
        begin
          if (!port.ben[l])
          begin
            mem[addr][l*LANE_WIDTH +: LANE_WIDTH] <= port.d[l*LANE_WIDTH +: LANE_WIDTH];
          end
        end
      end
      else
      begin
        port.q <= mem[addr];
      end
    end
  end

endmodule

/* verilog/sram_parity.sv */
`timescale 1ns/1ps

module sram_parity (
  input  logic    CLK,
  input  logic    rst_n,
  input  logic    inject,
  output logic    par_err,
  sram_if.slave   req,
  sram_if.master  data_mem,
  sram_if.master  par_mem
);
  import mem_pkg::*;

  // parity bits written with the data
  logic [NUM_LANES-1:0] wr_par;
  // parity recomputed from the data array's read word
  logic [NUM_LANES-1:0] rd_par;
  // lanes of the read issued in the previous cycle, zero otherwise
  logic [NUM_LANES-1:0] rd_lanes;

  // the data array sees the request unchanged
  assign data_mem.cen = req.cen;
  assign data_mem.a   = req.a;
  assign data_mem.wen = req.wen;
  assign data_mem.d   = req.d;
  assign data_mem.ben = req.ben;

  // even parity per lane, so data and parity together hold an even count of ones
  // inject flips every stored bit, which makes later reads of that word fail
  always_comb
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      wr_par[l] = (^req.d[l*LANE_WIDTH +: LANE_WIDTH]) ^ inject;
      rd_par[l] = ^data_mem.q[l*LANE_WIDTH +: LANE_WIDTH];
    end
  end

  // the parity array is one bit per lane, so the same mask covers it
  assign par_mem.cen = req.cen;
  assign par_mem.a   = req.a;
  assign par_mem.wen = req.wen;
  assign par_mem.d   = wr_par;
  assign par_mem.ben = req.ben;

  // remember which lanes the pending read checks
  // clearing it on every other cycle keeps par_err quiet outside read data
  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
      rd_lanes <= '0;
    else if (!req.cen && req.wen)
      rd_lanes <= ~req.ben;
    else
      rd_lanes <= '0;
  end

  assign req.q = data_mem.q;

  // valid in the cycle after the read request, alongside q
  assign par_err = |((rd_par ^ par_mem.q) & rd_lanes);

endmodule

/* verilog/err_log.sv */
`timescale 1ns/1ps

module err_log (
  input  logic                                CLK,
  input  logic                                rst_n,
  input  logic                                err_pulse,
  input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  err_word_addr,
  input  logic                                count_clr,
  output logic [apb_pkg::ERR_COUNT_WIDTH-1:0] err_count,
  output logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  err_addr
);

  // counter of failed reads
  // a clear in the same cycle as an error wins and leaves zero
  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      err_count <= '0;
    end
    else if (count_clr)
    begin
      err_count <= '0;
    end
    else if (err_pulse && (err_count != '1))
    begin
      // stops at all ones so a long error burst never reads back as few errors
      err_count <= err_count + 1'b1;
    end
  end

  // word address of the latest failed read
  // the clear leaves it alone, only a new error replaces it
  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      err_addr <= '0;
    end
    else if (err_pulse)
    begin
      err_addr <= err_word_addr;
    end
  end

endmodule

/* verilog/apb_mem_ctrl.sv */
`timescale 1ns/1ps

module apb_mem_ctrl (
  input  logic                                CLK,
  input  logic                                rst_n,
  input  logic [apb_pkg::PADDR_WIDTH-1:0]     paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [mem_pkg::DATA_WIDTH-1:0]      pwdata,
  input  logic [mem_pkg::NUM_LANES-1:0]       pstrb,
  output logic [mem_pkg::DATA_WIDTH-1:0]      prdata,
  output logic                                pready,
  output logic                                pslverr,
  sram_if.master                              mem,
  input  logic                                par_err,
  output logic                                inject,
  output logic                                err_pulse,
  output logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  err_word_addr,
  output logic                                count_clr,
  input  logic [apb_pkg::ERR_COUNT_WIDTH-1:0] err_count,
  input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  err_addr
);
  import mem_pkg::*;
  import apb_pkg::*;

  ctrl_state_t               state;
  ctrl_state_t               state_next;
  // first access cycle of a transfer
  logic                      access;
  // second access cycle of a memory read
  logic                      rd_done;
  logic                      reg_sel;
  logic                      reg_wr;
  logic                      reg_hit;
  logic [REG_SPACE_BIT-1:0]  reg_off;
  logic [DATA_WIDTH-1:0]     reg_rdata;
  logic [MEM_ADDR_WIDTH-1:0] word_addr;

  assign access    = (state == ACCESS) && psel && penable;
  assign rd_done   = (state == READ_WAIT) && psel && penable;
  assign reg_sel   = paddr[REG_SPACE_BIT];
  assign reg_off   = paddr[REG_SPACE_BIT-1:0];
  assign word_addr = paddr[BYTE_OFFSET_WIDTH +: MEM_ADDR_WIDTH];
  assign reg_wr    = access && reg_sel && pwrite;

  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= state_next;
  end

  // a setup phase moves to ACCESS
  // only a memory read needs the extra cycle for the array's registered q
  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (psel && !penable)
          state_next = ACCESS;
      end
      ACCESS:
      begin
        if (access && !reg_sel && !pwrite)
          state_next = READ_WAIT;
        else
          state_next = IDLE;
      end
      READ_WAIT:
        state_next = IDLE;
      default:
        state_next = IDLE;
    endcase
  end

  // register read mux, an offset outside the map reads zero and misses
  always_comb
  begin
    reg_hit   = 1'b1;
    reg_rdata = '0;
    case (reg_off)
      REG_CTRL:      reg_rdata = DATA_WIDTH'(inject);
      REG_ERR_COUNT: reg_rdata = DATA_WIDTH'(err_count);
      REG_ERR_ADDR:  reg_rdata = DATA_WIDTH'(err_addr);
      default:       reg_hit   = 1'b0;
    endcase
  end

  // memory writes and every register access finish in the first access cycle
  always_comb
  begin
    pready  = 1'b0;
    pslverr = 1'b0;
    prdata  = '0;
    if (rd_done)
    begin
      pready  = 1'b1;
      pslverr = par_err;
      prdata  = mem.q;
    end
    else if (access)
    begin
      if (reg_sel)
      begin
        pready  = 1'b1;
        pslverr = !reg_hit;
        prdata  = pwrite ? '0 : reg_rdata;
      end
      else if (pwrite)
      begin
        pready = 1'b1;
      end
    end
  end

  // one request per memory transfer, held low for the first access cycle only
  assign mem.cen = !(access && !reg_sel);
  assign mem.wen = !pwrite;
  assign mem.a   = word_addr;
  assign mem.d   = pwdata;
  // reads open every lane so the parity path checks the whole word
  assign mem.ben = pwrite ? ~pstrb : '0;

  // error injection control, bit 0 of REG_CTRL
  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
      inject <= 1'b0;
    else if (reg_wr && (reg_off == REG_CTRL))
      inject <= pwdata[0];
  end

  // any write to the count register clears it, whatever the data
  assign count_clr = reg_wr && (reg_off == REG_ERR_COUNT);

  // paddr is still stable in READ_WAIT, so it names the failing word
  assign err_pulse     = rd_done && par_err;
  assign err_word_addr = word_addr;

endmodule

/* verilog/apb_sram_top.sv */
`timescale 1ns/1ps

module apb_sram_top (
  input  logic                            CLK,
  input  logic                            rst_n,
  input  logic [apb_pkg::PADDR_WIDTH-1:0] PADDR,
  input  logic                            PSEL,
  input  logic                            PENABLE,
  input  logic                            PWRITE,
  input  logic [mem_pkg::DATA_WIDTH-1:0]  PWDATA,
  input  logic [mem_pkg::NUM_LANES-1:0]   PSTRB,
  output logic [mem_pkg::DATA_WIDTH-1:0]  PRDATA,
  output logic                            PREADY,
  output logic                            PSLVERR
);
  import mem_pkg::*;
  import apb_pkg::*;

  logic                       par_err;
  logic                       inject;
  logic                       err_pulse;
  logic                       count_clr;
  logic [MEM_ADDR_WIDTH-1:0]  err_word_addr;
  logic [MEM_ADDR_WIDTH-1:0]  err_addr;
  logic [ERR_COUNT_WIDTH-1:0] err_count;

  // controller to parity path, full data width
  sram_if #(.DW(DATA_WIDTH), .BW(NUM_LANES)) req_if ();
  // parity path to the data array
  sram_if #(.DW(DATA_WIDTH), .BW(NUM_LANES)) data_if ();
  // parity path to the parity array, one bit per lane
  sram_if #(.DW(NUM_LANES), .BW(NUM_LANES)) par_if ();

  apb_mem_ctrl ctrl_i (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .paddr         (PADDR),
    .psel          (PSEL),
    .penable       (PENABLE),
    .pwrite        (PWRITE),
    .pwdata        (PWDATA),
    .pstrb         (PSTRB),
    .prdata        (PRDATA),
    .pready        (PREADY),
    .pslverr       (PSLVERR),
    .mem           (req_if.master),
    .par_err       (par_err),
    .inject        (inject),
    .err_pulse     (err_pulse),
    .err_word_addr (err_word_addr),
    .count_clr     (count_clr),
    .err_count     (err_count),
    .err_addr      (err_addr)
  );

  sram_parity parity_i (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .inject   (inject),
    .par_err  (par_err),
    .req      (req_if.slave),
    .data_mem (data_if.master),
    .par_mem  (par_if.master)
  );

  // init_n follows reset so nothing is written while the design is held
  generic_memory #(
    .ADDR_WIDTH (MEM_ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .LANE_WIDTH (LANE_WIDTH)
  ) data_mem_i (
    .CLK    (CLK),
    .init_n (rst_n),
    .port   (data_if.slave)
  );

  generic_memory #(
    .ADDR_WIDTH (MEM_ADDR_WIDTH),
    .DATA_WIDTH (NUM_LANES),
    .LANE_WIDTH (1)
  ) par_mem_i (
    .CLK    (CLK),
    .init_n (rst_n),
    .port   (par_if.slave)
  );

  err_log err_log_i (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .err_pulse     (err_pulse),
    .err_word_addr (err_word_addr),
    .count_clr     (count_clr),
    .err_count     (err_count),
    .err_addr      (err_addr)
  );

endmodule

/* bench/apb_sram_sva.sv */
`timescale 1ns/1ps

module apb_sram_sva (
  input logic                            CLK,
  input logic                            rst_n,
  input logic [apb_pkg::PADDR_WIDTH-1:0] paddr,
  input logic                            psel,
  input logic                            penable,
  input logic                            pwrite,
  input logic [mem_pkg::DATA_WIDTH-1:0]  pwdata,
  input logic                            pready,
  input logic                            pslverr,
  input apb_pkg::ctrl_state_t            state
);
  import apb_pkg::*;

  // first access cycle of a memory read
  logic mem_rd_first;

  assign mem_rd_first = (state == ACCESS) && psel && penable && !pwrite && !paddr[REG_SPACE_BIT];

  // the master holds the transfer steady until the slave is ready
  setup_stable_a: assert property (@(posedge CLK) disable iff (!rst_n)
    (psel && !pready) |=> (psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
    else $error("APB setup signals changed before PREADY");

  // no response outside an access phase
  idle_quiet_a: assert property (@(posedge CLK) disable iff (!rst_n)
    !(psel && penable) |-> (!pready && !pslverr))
    else $error("PREADY or PSLVERR high outside an access phase");

  // the array's registered output costs a memory read exactly one wait state
  rd_one_wait_a: assert property (@(posedge CLK) disable iff (!rst_n)
    mem_rd_first |-> (!pready ##1 pready))
    else $error("memory read did not complete after exactly one wait state");

endmodule

bind apb_mem_ctrl apb_sram_sva sva_i (
  .CLK     (CLK),
  .rst_n   (rst_n),
  .paddr   (paddr),
  .psel    (psel),
  .penable (penable),
  .pwrite  (pwrite),
  .pwdata  (pwdata),
  .pready  (pready),
  .pslverr (pslverr),
  .state   (state)
);

/* bench/tb_apb_sram.sv */
`timescale 1ns/1ps

module tb_apb_sram;
  import mem_pkg::*;
  import apb_pkg::*;

  localparam int RANDOM_OPS = 200;
  // a transfer that waits longer than this is treated as hung
  localparam int MAX_WAITS = 16;
  localparam int NUM_WORDS = 2 ** MEM_ADDR_WIDTH;

  logic                   CLK;
  logic                   rst_n;
  logic [PADDR_WIDTH-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [DATA_WIDTH-1:0]  pwdata;
  logic [NUM_LANES-1:0]   pstrb;
  logic [DATA_WIDTH-1:0]  prdata;
  logic                   pready;
  logic                   pslverr;

  // directed vectors as loaded from the test file
  string                  t_name[$];
  string                  t_op[$];
  logic [PADDR_WIDTH-1:0] t_addr[$];
  logic [DATA_WIDTH-1:0]  t_data[$];
  logic [NUM_LANES-1:0]   t_strb[$];
  logic [DATA_WIDTH-1:0]  t_exp[$];
  logic                   t_err[$];

  // reference model of the scratchpad
  // ref_known marks lanes that were ever written, ref_bad marks lanes stored with inject set
  logic [DATA_WIDTH-1:0]  ref_mem[NUM_WORDS];
  logic [NUM_LANES-1:0]   ref_known[NUM_WORDS];
  logic [NUM_LANES-1:0]   ref_bad[NUM_WORDS];
  logic                   ref_inject;

  int                     n_run;
  int                     n_pass;
  int                     n_fail;
  int                     cycles = 0;
  int                     cycle_limit = 1000;
  logic [31:0]            rnd;

  apb_sram_top dut_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .PADDR   (paddr),
    .PSEL    (psel),
    .PENABLE (penable),
    .PWRITE  (pwrite),
    .PWDATA  (pwdata),
    .PSTRB   (pstrb),
    .PRDATA  (prdata),
    .PREADY  (pready),
    .PSLVERR (pslverr)
  );

  always #5 CLK = ~CLK;

  // the whole run is bounded by the number of transfers it makes
  always @(posedge CLK)
  begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // numerical recipes constants, upper bits are the useful ones
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // apply one write to the model, register writes only matter for REG_CTRL
  task automatic model_write(input logic [PADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data,
                             input logic [NUM_LANES-1:0] strb);
    logic [MEM_ADDR_WIDTH-1:0] w;
    w = addr[BYTE_OFFSET_WIDTH +: MEM_ADDR_WIDTH];
    if (addr[REG_SPACE_BIT])
    begin
      if (addr[REG_SPACE_BIT-1:0] == REG_CTRL)
        ref_inject = data[0];
    end
    else
    begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
        if (strb[l])
        begin
          ref_mem[w][l*LANE_WIDTH +: LANE_WIDTH] = data[l*LANE_WIDTH +: LANE_WIDTH];
          ref_known[w][l] = 1'b1;
          ref_bad[w][l]   = ref_inject;
        end
      end
    end
  endtask

  // one APB transfer, setup then access until PREADY
  // outputs are sampled on the falling edge where they are settled
  task automatic apb_transfer(input logic wr,
                              input logic [PADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data,
                              input logic [NUM_LANES-1:0] strb,
                              output logic [DATA_WIDTH-1:0] rdata,
                              output logic err,
                              output int waits,
                              output logic hung);
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    pstrb   <= strb;
    @(posedge CLK);
    penable <= 1'b1;
    waits = 0;
    @(negedge CLK);
    while (!pready && (waits < MAX_WAITS))
    begin
      waits++;
      @(negedge CLK);
    end
    hung  = !pready;
    rdata = prdata;
    err   = pslverr;
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // run one test and judge it, read data is only compared on reads
  task automatic run_test(input string name,
                          input logic wr,
                          input logic [PADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data,
                          input logic [NUM_LANES-1:0] strb,
                          input logic [DATA_WIDTH-1:0] exp_data,
                          input logic exp_err);
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
    logic                  hung;
    logic                  bad;
    int                    waits;
    int                    exp_waits;
    bad = 1'b0;
    // only a memory read has a wait state
    exp_waits = (!wr && !addr[REG_SPACE_BIT]) ? 1 : 0;
    apb_transfer(wr, addr, data, strb, rdata, err, waits, hung);
    n_run++;
    if (hung)
    begin
      $display("%s: PREADY never rose within %0d cycles", name, MAX_WAITS);
      bad = 1'b1;
    end
    else
    begin
      if (!wr && (rdata !== exp_data))
      begin
        $display("MISMATCH %s prdata expected %h actual %h", name, exp_data, rdata);
        bad = 1'b1;
      end
      if (err !== exp_err)
      begin
        $display("MISMATCH %s pslverr expected %b actual %b", name, exp_err, err);
        bad = 1'b1;
      end
      if (waits != exp_waits)
      begin
        $display("%s: PREADY came after %0d wait states instead of %0d", name, waits, exp_waits);
        bad = 1'b1;
      end
    end
    if (wr)
      model_write(addr, data, strb);
    if (bad)
    begin
      n_fail++;
      $display("test %s failed", name);
    end
    else
    begin
      n_pass++;
      $display("test %s ok", name);
    end
  endtask

  initial
  begin
    int                        fd;
    string                     line;
    string                     name;
    string                     op;
    logic [31:0]               a;
    logic [31:0]               d;
    logic [31:0]               s;
    logic [31:0]               e;
    logic [31:0]               r;
    logic [MEM_ADDR_WIDTH-1:0] w;
    logic [NUM_LANES-1:0]      st;
    logic [MEM_ADDR_WIDTH-1:0] rnd_words[$];
    CLK        = 1'b0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pstrb      = '0;
    n_run      = 0;
    n_pass     = 0;
    n_fail     = 0;
    ref_inject = 1'b0;
    rnd        = 32'h4ded4e11;
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      ref_mem[i]   = '0;
      ref_known[i] = '0;
      ref_bad[i]   = '0;
    end

    // lines starting with # are column notes
    fd = $fopen("bench/apb_sram_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open bench/apb_sram_tests.txt");
      n_fail++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if ((line.len() > 0) && (line.substr(0, 0) != "#") &&
            ($sscanf(line, "%s %s %h %h %h %h %h", name, op, a, d, s, e, r) == 7))
        begin
          t_name.push_back(name);
          t_op.push_back(op);
          t_addr.push_back(a[PADDR_WIDTH-1:0]);
          t_data.push_back(d);
          t_strb.push_back(s[NUM_LANES-1:0]);
          t_exp.push_back(e);
          t_err.push_back(r[0]);
        end
      end
      $fclose(fd);
    end
    // a read takes four cycles at most, writes take three
    cycle_limit = (t_name.size() + 2 * RANDOM_OPS) * 4 + 200;

    repeat (5) @(posedge CLK);
    rst_n <= 1'b1;

    foreach (t_name[i])
    begin
      run_test(t_name[i], t_op[i] == "write", t_addr[i], t_data[i], t_strb[i],
               t_exp[i], t_err[i]);
    end

    // lanes never written are forced into the strobe so no read sees undefined bytes
    for (int i = 0; i < RANDOM_OPS; i++)
    begin
      rnd = lcg_next(rnd);
      w   = rnd[25:16];
      rnd = lcg_next(rnd);
      d   = rnd;
      rnd = lcg_next(rnd);
      st  = rnd[19:16] | ~ref_known[w];
      a   = 32'(w) << BYTE_OFFSET_WIDTH;
      rnd_words.push_back(w);
      run_test($sformatf("rnd_wr_%0d", i), 1'b1, a[PADDR_WIDTH-1:0], d, st, '0, 1'b0);
    end
    foreach (rnd_words[i])
    begin
      w = rnd_words[i];
      a = 32'(w) << BYTE_OFFSET_WIDTH;
      run_test($sformatf("rnd_rd_%0d", i), 1'b0, a[PADDR_WIDTH-1:0], '0, '0,
               ref_mem[w], |ref_bad[w]);
    end

    $display("tests run %0d, passed %0d, failed %0d", n_run, n_pass, n_fail);
    if (n_fail == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* bench/apb_sram_tests.txt */
# name op addr data strobe expected_data expected_pslverr
# addr is the APB byte address, all numbers in hex, expected_data is only checked on reads
wr_full       write 0010 deadbeef f 00000000 0
rd_full       read  0010 00000000 0 deadbeef 0
wr_base       write 0020 11223344 f 00000000 0
wr_strb_5     write 0020 aabbccdd 5 00000000 0
rd_strb_5     read  0020 00000000 0 11bb33dd 0
wr_strb_a     write 0020 55667788 a 00000000 0
rd_strb_a     read  0020 00000000 0 55bb77dd 0
rd_count_0    read  1004 00000000 0 00000000 0
wr_inject_on  write 1000 00000001 f 00000000 0
rd_ctrl       read  1000 00000000 0 00000001 0
wr_inj_word   write 0030 cafef00d f 00000000 0
wr_inject_off write 1000 00000000 f 00000000 0
rd_inj_word   read  0030 00000000 0 cafef00d 1
rd_inj_again  read  0030 00000000 0 cafef00d 1
rd_count_2    read  1004 00000000 0 00000002 0
rd_err_addr   read  1008 00000000 0 0000000c 0
wr_fix_word   write 0030 0badc0de f 00000000 0
rd_fix_word   read  0030 00000000 0 0badc0de 0
wr_clr_count  write 1004 12345678 f 00000000 0
rd_count_clr  read  1004 00000000 0 00000000 0
rd_unmapped   read  100c 00000000 0 00000000 1
wr_unmapped   write 1ff0 ffffffff f 00000000 1

/* tb.f */
verilog/mem_pkg.sv
verilog/apb_pkg.sv
verilog/sram_if.sv
verilog/generic_memory.sv
verilog/sram_parity.sv
verilog/err_log.sv
verilog/apb_mem_ctrl.sv
verilog/apb_sram_top.sv
bench/apb_sram_sva.sv
bench/tb_apb_sram.sv

/* Bender.yml */
package:
  name: apb_sram

sources:
  # design sources, packages first
  - files:
      - verilog/mem_pkg.sv
      - verilog/apb_pkg.sv
      - verilog/sram_if.sv
      - verilog/generic_memory.sv
      - verilog/sram_parity.sv
      - verilog/err_log.sv
      - verilog/apb_mem_ctrl.sv
      - verilog/apb_sram_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - bench/apb_sram_sva.sv
      - bench/tb_apb_sram.sv
